//--- Bender.yml
package:
  name: data_mmu

sources:
  - rtl/mmu_pkg.sv
  - rtl/tlb_lookup_if.sv
  - rtl/data_tlb.sv
  - rtl/ld_st_translate.sv
  - rtl/data_mmu.sv
  - target: test
    files:
      - verification/tb_data_mmu.sv

//--- rtl/data_mmu.sv
// ----------------------------------------
// data-side sv39 MMU top level
// joins the data TLB and the load/store
// translate stage
// ----------------------------------------
`timescale 1ns/100ps

module data_mmu import mmu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_tlb_i,
    input  logic                en_ld_st_translation_i,
    // lsu request
    input  logic                lsu_req_i,
    input  logic [VLEN-1:0]     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    input  logic [1:0]          ld_st_priv_lvl_i,
    input  logic                sum_i,
    input  logic [ASID_W-1:0]   asid_i,
    // TLB fill from the core
    input  logic                update_valid_i,
    input  logic [3*VPN_W-1:0]  update_vpn_i,
    input  logic [ASID_W-1:0]   update_asid_i,
    input  logic                update_is_2m_i,
    input  logic                update_is_1g_i,
    input  logic [PTE_W-1:0]    update_pte_i,
    // cycle 0
    output logic                lsu_dtlb_hit_o,
    output logic [PPNW-1:0]     lsu_dtlb_ppn_o,
    output logic                dtlb_miss_o,
    // cycle 1
    output logic                lsu_valid_o,
    output logic [PLEN-1:0]     lsu_paddr_o,
    output logic                lsu_ex_valid_o,
    output logic [XLEN-1:0]     lsu_ex_cause_o,
    output logic [XLEN-1:0]     lsu_ex_tval_o
);

    // lookup path between the stages
    tlb_lookup_if dtlb_lu ();

    data_tlb i_dtlb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_tlb_i    (flush_tlb_i),
        .update_valid_i (update_valid_i),
        .update_vpn_i   (update_vpn_i),
        .update_asid_i  (update_asid_i),
        .update_is_2m_i (update_is_2m_i),
        .update_is_1g_i (update_is_1g_i),
        .update_pte_i   (update_pte_i),
        .lookup         (dtlb_lu.responder)
    );

    ld_st_translate i_ld_st_translate (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .lsu_req_i              (lsu_req_i),
        .lsu_vaddr_i            (lsu_vaddr_i),
        .lsu_is_store_i         (lsu_is_store_i),
        .ld_st_priv_lvl_i       (ld_st_priv_lvl_i),
        .sum_i                  (sum_i),
        .asid_i                 (asid_i),
        .lookup                 (dtlb_lu.requester),
        .lsu_dtlb_hit_o         (lsu_dtlb_hit_o),
        .lsu_dtlb_ppn_o         (lsu_dtlb_ppn_o),
        .dtlb_miss_o            (dtlb_miss_o),
        .lsu_valid_o            (lsu_valid_o),
        .lsu_paddr_o            (lsu_paddr_o),
        .lsu_ex_valid_o         (lsu_ex_valid_o),
        .lsu_ex_cause_o         (lsu_ex_cause_o),
        .lsu_ex_tval_o          (lsu_ex_tval_o)
    );

endmodule

//--- rtl/data_tlb.sv
// ----------------------------------------
// fully associative data TLB for sv39
// asid and global match, 4k/2m/1g pages,
// round-robin fill and full flush
// ----------------------------------------
`timescale 1ns/100ps

module data_tlb import mmu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_tlb_i,
    // fill port from the core
    input  logic                update_valid_i,
    input  logic [3*VPN_W-1:0]  update_vpn_i,
    input  logic [ASID_W-1:0]   update_asid_i,
    input  logic                update_is_2m_i,
    input  logic                update_is_1g_i,
    input  logic [PTE_W-1:0]    update_pte_i,
    // lookup from the translate stage
    tlb_lookup_if.responder     lookup
);

    // ----------------------------------------
    // entry store
    // ----------------------------------------
    logic [DTLB_ENTRIES-1:0]         valid_q;
    logic [ASID_W-1:0]               asid_q  [DTLB_ENTRIES];
    logic [VPN_W-1:0]                vpn2_q  [DTLB_ENTRIES];
    logic [VPN_W-1:0]                vpn1_q  [DTLB_ENTRIES];
    logic [VPN_W-1:0]                vpn0_q  [DTLB_ENTRIES];
    logic [DTLB_ENTRIES-1:0]         is_2m_q;
    logic [DTLB_ENTRIES-1:0]         is_1g_q;
    logic [PTE_W-1:0]                pte_q   [DTLB_ENTRIES];

    // next entry to be replaced
    logic [$clog2(DTLB_ENTRIES)-1:0] fill_ptr_q;
    // per-entry tag match
    logic [DTLB_ENTRIES-1:0]         match;

    // ----------------------------------------
    // tag match
    // ----------------------------------------
    for (genvar i = 0; i < DTLB_ENTRIES; i++) begin : g_match
        logic asid_ok;
        logic vpn2_ok;
        logic vpn1_ok;
        logic vpn0_ok;

        // global pages ignore the asid
        assign asid_ok = (asid_q[i] == lookup.asid) || pte_q[i][PTE_G_BIT];
        assign vpn2_ok = (vpn2_q[i] == lookup.vaddr.sv39.vpn2);
        assign vpn1_ok = (vpn1_q[i] == lookup.vaddr.sv39.vpn1);
        assign vpn0_ok = (vpn0_q[i] == lookup.vaddr.sv39.vpn0);

        // 1g needs vpn2 only, 2m adds vpn1, 4k needs all three
        assign match[i] = valid_q[i] && asid_ok && vpn2_ok
                          && (is_1g_q[i] || (vpn1_ok && (is_2m_q[i] || vpn0_ok)));
    end

    // ----------------------------------------
    // answer select
    // ----------------------------------------
    always_comb begin : hit_select
        lookup.hit   = 1'b0;
        lookup.pte   = '0;
        lookup.is_2m = 1'b0;
        lookup.is_1g = 1'b0;
        // walk downwards so the lowest matching entry is the one reported
        for (int i = int'(DTLB_ENTRIES) - 1; i >= 0; i--) begin
            if (lookup.access && match[i]) begin
                lookup.hit   = 1'b1;
                lookup.pte   = pte_q[i];
                lookup.is_2m = is_2m_q[i];
                lookup.is_1g = is_1g_q[i];
            end
        end
    end

    // ----------------------------------------
    // valid bits and replacement pointer
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            fill_ptr_q <= '0;
        end else if (flush_tlb_i) begin
            // flush beats a fill in the same cycle
            valid_q <= '0;
        end else if (update_valid_i) begin
            valid_q[fill_ptr_q] <= 1'b1;
            fill_ptr_q <= (fill_ptr_q == DTLB_ENTRIES - 1) ? '0 : fill_ptr_q + 1'b1;
        end
    end

    // entry payload, written at the pointer
    always_ff @(posedge clk_i) begin
        if (update_valid_i && !flush_tlb_i) begin
            asid_q[fill_ptr_q]  <= update_asid_i;
            vpn2_q[fill_ptr_q]  <= update_vpn_i[3*VPN_W-1:2*VPN_W];
            vpn1_q[fill_ptr_q]  <= update_vpn_i[2*VPN_W-1:VPN_W];
            vpn0_q[fill_ptr_q]  <= update_vpn_i[VPN_W-1:0];
            is_2m_q[fill_ptr_q] <= update_is_2m_i;
            is_1g_q[fill_ptr_q] <= update_is_1g_i;
            pte_q[fill_ptr_q]   <= update_pte_i;
        end
    end

endmodule

//--- rtl/ld_st_translate.sv
// ----------------------------------------
// load/store address translation
// same-cycle TLB answer, one register stage,
// physical address and page-fault checks
// ----------------------------------------
`timescale 1ns/100ps

module ld_st_translate import mmu_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                en_ld_st_translation_i,
    // request from the lsu
    input  logic                lsu_req_i,
    input  logic [VLEN-1:0]     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    input  logic [1:0]          ld_st_priv_lvl_i,
    input  logic                sum_i,
    input  logic [ASID_W-1:0]   asid_i,
    // TLB lookup
    tlb_lookup_if.requester     lookup,
    // cycle 0 answer
    output logic                lsu_dtlb_hit_o,
    output logic [PPNW-1:0]     lsu_dtlb_ppn_o,
    output logic                dtlb_miss_o,
    // cycle 1 result
    output logic                lsu_valid_o,
    output logic [PLEN-1:0]     lsu_paddr_o,
    output logic                lsu_ex_valid_o,
    output logic [XLEN-1:0]     lsu_ex_cause_o,
    output logic [XLEN-1:0]     lsu_ex_tval_o
);

    // leaf ppn with superpage bits taken from the virtual address
    function automatic logic [PPNW-1:0] leaf_ppn(
        input logic [PTE_W-1:0] pte,
        input sv39_vaddr_u      va,
        input logic             is_2m,
        input logic             is_1g
    );
        logic [PPNW-1:0] ppn;
        ppn = pte[PTE_PPN_LSB +: PPNW];
        if (is_2m) begin
            ppn[VPN_W-1:0] = va.sv39.vpn0;
        end
        if (is_1g) begin
            ppn[2*VPN_W-1:0] = {va.sv39.vpn1, va.sv39.vpn0};
        end
        return ppn;
    endfunction

    sv39_vaddr_u      vaddr_d;

    // stage registers
    logic             req_q;
    logic             hit_q;
    logic             store_q;
    sv39_vaddr_u      vaddr_q;
    logic [PTE_W-1:0] pte_q;
    logic             is_2m_q;
    logic             is_1g_q;

    logic             access_err;
    logic             store_fault;
    logic             fault_check;
    logic [XLEN-1:0]  vaddr_sext;

    // ----------------------------------------
    // cycle 0, lookup and same-cycle answer
    // ----------------------------------------
    assign vaddr_d       = lsu_vaddr_i;
    assign lookup.access = lsu_req_i;
    assign lookup.asid   = asid_i;
    assign lookup.vaddr  = vaddr_d;

    // bare mode is always ready
    assign lsu_dtlb_hit_o = en_ld_st_translation_i ? lookup.hit : 1'b1;
    // asks the core for a fill
    assign dtlb_miss_o    = lsu_req_i && en_ld_st_translation_i && !lookup.hit;

    assign lsu_dtlb_ppn_o = en_ld_st_translation_i
                            ? leaf_ppn(lookup.pte, vaddr_d, lookup.is_2m, lookup.is_1g)
                            : PPNW'(vaddr_d.raw[VLEN-1:PAGE_OFFSET_W]);

    // ----------------------------------------
    // register stage
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= lookup.hit;
        end
    end

    // payload, only looked at while req_q is set
    always_ff @(posedge clk_i) begin
        store_q <= lsu_is_store_i;
        vaddr_q <= vaddr_d;
        pte_q   <= lookup.pte;
        is_2m_q <= lookup.is_2m;
        is_1g_q <= lookup.is_1g;
    end

    // ----------------------------------------
    // cycle 1, physical address
    // ----------------------------------------
    // a miss stays silent, the core refills and retries
    assign lsu_valid_o = req_q && (!en_ld_st_translation_i || hit_q);

    assign lsu_paddr_o = en_ld_st_translation_i
                         ? {leaf_ppn(pte_q, vaddr_q, is_2m_q, is_1g_q), vaddr_q.sv39.offset}
                         : PLEN'(vaddr_q.raw);

    // ----------------------------------------
    // cycle 1, page-fault checks
    // ----------------------------------------
    always_comb begin : priv_check
        case (ld_st_priv_lvl_i)
            // user pages need sum in supervisor mode
            PRIV_LVL_S: access_err = !sum_i && pte_q[PTE_U_BIT];
            // user mode may only touch user pages
            PRIV_LVL_U: access_err = !pte_q[PTE_U_BIT];
            PRIV_LVL_M: access_err = 1'b0;
            default:    access_err = 1'b0;
        endcase
    end

    // stores also need write permission and a set dirty bit
    assign store_fault = !pte_q[PTE_W_BIT] || !pte_q[PTE_D_BIT] || access_err;
    assign fault_check = en_ld_st_translation_i && req_q && hit_q;
    assign vaddr_sext  = {{(XLEN-VLEN){vaddr_q.raw[VLEN-1]}}, vaddr_q.raw};

    always_comb begin : page_fault
        lsu_ex_valid_o = 1'b0;
        lsu_ex_cause_o = '0;
        lsu_ex_tval_o  = '0;
        if (fault_check) begin
            if (store_q && store_fault) begin
                lsu_ex_valid_o = 1'b1;
                lsu_ex_cause_o = CAUSE_STORE_PAGE_FAULT;
                lsu_ex_tval_o  = vaddr_sext;
            end else if (!store_q && access_err) begin
                lsu_ex_valid_o = 1'b1;
                lsu_ex_cause_o = CAUSE_LOAD_PAGE_FAULT;
                lsu_ex_tval_o  = vaddr_sext;
            end
        end
    end

endmodule

//--- rtl/mmu_pkg.sv
// ----------------------------------------
// shared definitions for the SV39 data MMU
// address widths, PTE flag positions,
// privilege and cause codes, TLB size
// ----------------------------------------
package mmu_pkg;

    // ----------------------------------------
    // address widths
    // ----------------------------------------
    // sv39 virtual address
    localparam int unsigned VLEN = 39;
    // physical address and page number
    localparam int unsigned PLEN = 56;
    localparam int unsigned PPNW = 44;
    // cause and tval words
    localparam int unsigned XLEN = 64;
    localparam int unsigned ASID_W = 16;
    localparam int unsigned PTE_W = 64;

    // 4 KiB page offset
    localparam int unsigned PAGE_OFFSET_W = 12;
    // one level of the sv39 page number
    localparam int unsigned VPN_W = 9;

    // ----------------------------------------
    // PTE layout
    // ----------------------------------------
    localparam int unsigned PTE_V_BIT = 0;
    localparam int unsigned PTE_R_BIT = 1;
    localparam int unsigned PTE_W_BIT = 2;
    localparam int unsigned PTE_X_BIT = 3;
    localparam int unsigned PTE_U_BIT = 4;
    localparam int unsigned PTE_G_BIT = 5;
    localparam int unsigned PTE_A_BIT = 6;
    localparam int unsigned PTE_D_BIT = 7;
    // ppn starts above the two rsw bits
    localparam int unsigned PTE_PPN_LSB = 10;

    // number of data TLB entries
    localparam int unsigned DTLB_ENTRIES = 4;

    // ----------------------------------------
    // privilege and cause codes
    // ----------------------------------------
    localparam logic [1:0] PRIV_LVL_U = 2'd0;
    localparam logic [1:0] PRIV_LVL_S = 2'd1;
    localparam logic [1:0] PRIV_LVL_M = 2'd3;

    // mcause/scause values for data page faults
    localparam logic [XLEN-1:0] CAUSE_LOAD_PAGE_FAULT = XLEN'(13);
    localparam logic [XLEN-1:0] CAUSE_STORE_PAGE_FAULT = XLEN'(15);

    // ----------------------------------------
    // virtual address views
    // ----------------------------------------
    // raw word for forwarding and tval,
    // page number fields for tag match and superpage fill
    typedef union packed {
        logic [VLEN-1:0] raw;
        struct packed {
            // gigapage index
            logic [VPN_W-1:0]         vpn2;
            // megapage index
            logic [VPN_W-1:0]         vpn1;
            // 4k page index
            logic [VPN_W-1:0]         vpn0;
            logic [PAGE_OFFSET_W-1:0] offset;
        } sv39;
    } sv39_vaddr_u;

endpackage

//--- rtl/tlb_lookup_if.sv
// ----------------------------------------
// lookup port between the load/store
// translate stage and the data TLB
// ----------------------------------------
`timescale 1ns/100ps

interface tlb_lookup_if import mmu_pkg::*; ();

    // request side
    logic              access;
    logic [ASID_W-1:0] asid;
    sv39_vaddr_u       vaddr;

    // answer, combinational in the request cycle
    logic              hit;
    logic [PTE_W-1:0]  pte;
    logic              is_2m;
    logic              is_1g;

    // translate stage side
    modport requester (
        output access,
        output asid,
        output vaddr,
        input  hit,
        input  pte,
        input  is_2m,
        input  is_1g
    );

    // TLB side
    modport responder (
        input  access,
        input  asid,
        input  vaddr,
        output hit,
        output pte,
        output is_2m,
        output is_1g
    );

endinterface

//--- tb.f
rtl/mmu_pkg.sv
rtl/tlb_lookup_if.sv
rtl/data_tlb.sv
rtl/ld_st_translate.sv
rtl/data_mmu.sv
verification/tb_data_mmu.sv

//--- verification/tb_data_mmu.sv
// ----------------------------------------
// directed testbench for the data MMU
// bare mode, fill and hit, superpages,
// page faults, asid and flush
// ----------------------------------------
`timescale 1ns/100ps

module tb_data_mmu import mmu_pkg::*; ();

    // well above the length of all tests
    localparam int unsigned MAX_CYCLES = 2000;

    logic                clk_i;
    logic                rst_ni;
    logic                flush_tlb_i;
    logic                en_ld_st_translation_i;
    logic                lsu_req_i;
    logic [VLEN-1:0]     lsu_vaddr_i;
    logic                lsu_is_store_i;
    logic [1:0]          ld_st_priv_lvl_i;
    logic                sum_i;
    logic [ASID_W-1:0]   asid_i;
    logic                update_valid_i;
    logic [3*VPN_W-1:0]  update_vpn_i;
    logic [ASID_W-1:0]   update_asid_i;
    logic                update_is_2m_i;
    logic                update_is_1g_i;
    logic [PTE_W-1:0]    update_pte_i;
    logic                lsu_dtlb_hit_o;
    logic [PPNW-1:0]     lsu_dtlb_ppn_o;
    logic                dtlb_miss_o;
    logic                lsu_valid_o;
    logic [PLEN-1:0]     lsu_paddr_o;
    logic                lsu_ex_valid_o;
    logic [XLEN-1:0]     lsu_ex_cause_o;
    logic [XLEN-1:0]     lsu_ex_tval_o;

    // responses captured by the request task
    logic                got_hit;
    logic [PPNW-1:0]     got_ppn;
    logic                got_miss;
    logic                got_valid;
    logic [PLEN-1:0]     got_paddr;
    logic                got_ex;
    logic [XLEN-1:0]     got_cause;
    logic [XLEN-1:0]     got_tval;

    int unsigned         errors = 0;
    int unsigned         cycles = 0;

    data_mmu dut0 (.*);

    // 4 ns clock
    always #2 clk_i = ~clk_i;

    // ----------------------------------------
    // run limit
    // ----------------------------------------
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_paddr(input string name, input logic [PLEN-1:0] got,
                               input logic [PLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ppn(input string name, input logic [PPNW-1:0] got,
                             input logic [PPNW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    // leaf pte that is always valid, readable and accessed
    function automatic logic [PTE_W-1:0] make_pte(input logic [PPNW-1:0] ppn,
                                                  input logic u, input logic w,
                                                  input logic d, input logic g);
        logic [PTE_W-1:0] pte;
        pte = '0;
        pte[PTE_PPN_LSB +: PPNW] = ppn;
        pte[PTE_V_BIT] = 1'b1;
        pte[PTE_R_BIT] = 1'b1;
        pte[PTE_A_BIT] = 1'b1;
        pte[PTE_U_BIT] = u;
        pte[PTE_W_BIT] = w;
        pte[PTE_D_BIT] = d;
        pte[PTE_G_BIT] = g;
        return pte;
    endfunction

    function automatic logic [PPNW-1:0] rand_ppn();
        return PPNW'({$urandom(), $urandom()});
    endfunction

    task automatic load_pte(input logic [3*VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid,
                            input logic is_2m, input logic is_1g,
                            input logic [PTE_W-1:0] pte);
        @(negedge clk_i);
        update_valid_i = 1'b1;
        update_vpn_i   = vpn;
        update_asid_i  = asid;
        update_is_2m_i = is_2m;
        update_is_1g_i = is_1g;
        update_pte_i   = pte;
        @(negedge clk_i);
        update_valid_i = 1'b0;
    endtask

    task automatic flush_all();
        @(negedge clk_i);
        flush_tlb_i = 1'b1;
        @(negedge clk_i);
        flush_tlb_i = 1'b0;
    endtask

    // one request with its cycle 0 answer and cycle 1 result
    // mode inputs stay put until the next request
    task automatic request(input logic en, input logic [1:0] priv, input logic sum_on,
                           input logic [ASID_W-1:0] asid, input logic [VLEN-1:0] vaddr,
                           input logic store);
        @(negedge clk_i);
        en_ld_st_translation_i = en;
        ld_st_priv_lvl_i       = priv;
        sum_i                  = sum_on;
        asid_i                 = asid;
        lsu_vaddr_i            = vaddr;
        lsu_is_store_i         = store;
        lsu_req_i              = 1'b1;
        #1;
        got_hit  = lsu_dtlb_hit_o;
        got_ppn  = lsu_dtlb_ppn_o;
        got_miss = dtlb_miss_o;
        @(negedge clk_i);
        lsu_req_i = 1'b0;
        #1;
        got_valid = lsu_valid_o;
        got_paddr = lsu_paddr_o;
        got_ex    = lsu_ex_valid_o;
        got_cause = lsu_ex_cause_o;
        got_tval  = lsu_ex_tval_o;
    endtask

    task automatic expect_hit(input logic [PPNW-1:0] ppn);
        check_bit("lsu_dtlb_hit_o", got_hit, 1'b1);
        check_bit("dtlb_miss_o", got_miss, 1'b0);
        check_ppn("lsu_dtlb_ppn_o", got_ppn, ppn);
    endtask

    // a miss asks for a fill and gives no result
    task automatic expect_miss();
        check_bit("lsu_dtlb_hit_o", got_hit, 1'b0);
        check_bit("dtlb_miss_o", got_miss, 1'b1);
        check_bit("lsu_valid_o", got_valid, 1'b0);
        check_bit("lsu_ex_valid_o", got_ex, 1'b0);
    endtask

    task automatic expect_done(input logic [PLEN-1:0] paddr, input logic ex,
                               input logic [XLEN-1:0] cause, input logic [VLEN-1:0] vaddr);
        check_bit("lsu_valid_o", got_valid, 1'b1);
        check_paddr("lsu_paddr_o", got_paddr, paddr);
        check_bit("lsu_ex_valid_o", got_ex, ex);
        if (ex) begin
            check_word("lsu_ex_cause_o", got_cause, cause);
            // tval is the sign-extended virtual address
            check_word("lsu_ex_tval_o", got_tval, XLEN'($signed(vaddr)));
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic bare_mode_test();
        logic [VLEN-1:0] va;
        va = VLEN'({$urandom(), $urandom()});
        request(1'b0, PRIV_LVL_U, 1'b0, 16'h0001, va, 1'b1);
        check_bit("lsu_dtlb_hit_o", got_hit, 1'b1);
        check_bit("dtlb_miss_o", got_miss, 1'b0);
        check_ppn("lsu_dtlb_ppn_o", got_ppn, PPNW'(va[VLEN-1:PAGE_OFFSET_W]));
        expect_done(PLEN'(va), 1'b0, '0, va);
    endtask

    task automatic page_4k_test();
        logic [PPNW-1:0]          ppn;
        logic [PAGE_OFFSET_W-1:0] off;
        logic [VLEN-1:0]          va;
        ppn = rand_ppn();
        off = PAGE_OFFSET_W'($urandom());
        va  = {9'h001, 9'h023, 9'h045, off};
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b0);
        expect_miss();
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 0, 1, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b0);
        expect_hit(ppn);
        expect_done({ppn, off}, 1'b0, '0, va);
    endtask

    task automatic superpage_test();
        logic [PPNW-1:0]          ppn;
        logic [PPNW-1:0]          exp_ppn;
        logic [VPN_W-1:0]         v1;
        logic [VPN_W-1:0]         v0;
        logic [PAGE_OFFSET_W-1:0] off;
        logic [VLEN-1:0]          va;
        // 2 MiB page where vpn0 passes through
        ppn = rand_ppn();
        v0  = VPN_W'($urandom());
        off = PAGE_OFFSET_W'($urandom());
        va  = {9'h002, 9'h011, v0, off};
        load_pte({9'h002, 9'h011, 9'h000}, 16'h0005, 1'b1, 1'b0, make_pte(ppn, 0, 1, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b0);
        exp_ppn = {ppn[PPNW-1:VPN_W], v0};
        expect_hit(exp_ppn);
        expect_done({exp_ppn, off}, 1'b0, '0, va);
        // 1 GiB page where vpn1 and vpn0 pass through
        ppn = rand_ppn();
        v1  = VPN_W'($urandom());
        v0  = VPN_W'($urandom());
        off = PAGE_OFFSET_W'($urandom());
        va  = {9'h003, v1, v0, off};
        load_pte({9'h003, 18'h0}, 16'h0005, 1'b0, 1'b1, make_pte(ppn, 0, 1, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b0);
        exp_ppn = {ppn[PPNW-1:2*VPN_W], v1, v0};
        expect_hit(exp_ppn);
        expect_done({exp_ppn, off}, 1'b0, '0, va);
    endtask

    task automatic store_fault_test();
        logic [PPNW-1:0] ppn;
        logic [VLEN-1:0] va;
        // top vpn2 bit set so tval sign-extends with ones
        ppn = rand_ppn();
        va  = {9'h1f0, 9'h001, 9'h002, 12'h3a8};
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 0, 0, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b1);
        expect_done({ppn, 12'h3a8}, 1'b1, 64'd15, va);
        // dirty bit clear
        ppn = rand_ppn();
        va  = {9'h1f1, 9'h001, 9'h002, 12'h010};
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 0, 1, 0, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b1);
        expect_done({ppn, 12'h010}, 1'b1, 64'd15, va);
        // writable and dirty
        ppn = rand_ppn();
        va  = {9'h1f2, 9'h001, 9'h002, 12'hff8};
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 0, 1, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b1);
        expect_done({ppn, 12'hff8}, 1'b0, '0, va);
    endtask

    task automatic privilege_test();
        logic [PPNW-1:0] ppn;
        logic [VLEN-1:0] va;
        // user load from a supervisor page
        ppn = rand_ppn();
        va  = {9'h0a7, 9'h004, 9'h005, 12'h120};
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 0, 1, 1, 0));
        request(1'b1, PRIV_LVL_U, 1'b0, 16'h0005, va, 1'b0);
        expect_done({ppn, 12'h120}, 1'b1, 64'd13, va);
        // supervisor load from a user page with sum off then on
        ppn = rand_ppn();
        va  = {9'h0a8, 9'h004, 9'h005, 12'h7f0};
        load_pte(va[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0, make_pte(ppn, 1, 1, 1, 0));
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va, 1'b0);
        expect_done({ppn, 12'h7f0}, 1'b1, 64'd13, va);
        request(1'b1, PRIV_LVL_S, 1'b1, 16'h0005, va, 1'b0);
        expect_done({ppn, 12'h7f0}, 1'b0, '0, va);
    endtask

    task automatic asid_flush_test();
        logic [PPNW-1:0] ppn_a;
        logic [PPNW-1:0] ppn_g;
        logic [VLEN-1:0] va_a;
        logic [VLEN-1:0] va_g;
        ppn_a = rand_ppn();
        ppn_g = rand_ppn();
        va_a  = {9'h0b0, 9'h006, 9'h007, 12'h040};
        va_g  = {9'h0b1, 9'h006, 9'h007, 12'h080};
        load_pte(va_a[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0,
                 make_pte(ppn_a, 0, 1, 1, 0));
        load_pte(va_g[VLEN-1:PAGE_OFFSET_W], 16'h0005, 1'b0, 1'b0,
                 make_pte(ppn_g, 0, 1, 1, 1));
        // non-global entry only under its own asid
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0006, va_a, 1'b0);
        expect_miss();
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va_a, 1'b0);
        expect_hit(ppn_a);
        expect_done({ppn_a, 12'h040}, 1'b0, '0, va_a);
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h1234, va_g, 1'b0);
        expect_hit(ppn_g);
        expect_done({ppn_g, 12'h080}, 1'b0, '0, va_g);
        // everything gone after the flush
        flush_all();
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va_a, 1'b0);
        expect_miss();
        request(1'b1, PRIV_LVL_S, 1'b0, 16'h0005, va_g, 1'b0);
        expect_miss();
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h7c61f342));
        clk_i                  = 1'b0;
        rst_ni                 = 1'b0;
        flush_tlb_i            = 1'b0;
        en_ld_st_translation_i = 1'b0;
        lsu_req_i              = 1'b0;
        lsu_vaddr_i            = '0;
        lsu_is_store_i         = 1'b0;
        ld_st_priv_lvl_i       = PRIV_LVL_M;
        sum_i                  = 1'b0;
        asid_i                 = '0;
        update_valid_i         = 1'b0;
        update_vpn_i           = '0;
        update_asid_i          = '0;
        update_is_2m_i         = 1'b0;
        update_is_1g_i         = 1'b0;
        update_pte_i           = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // outputs quiet after reset
        check_bit("lsu_valid_o", lsu_valid_o, 1'b0);
        check_bit("lsu_ex_valid_o", lsu_ex_valid_o, 1'b0);
        check_bit("dtlb_miss_o", dtlb_miss_o, 1'b0);

        bare_mode_test();
        page_4k_test();
        superpage_test();
        store_fault_test();
        privilege_test();
        asid_flush_test();

        @(negedge clk_i);
        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
